/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tft_ctrl_tb
RTL_TOP    ?= tft_ctrl_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/tft_bus_pkg.sv */
package tft_bus_pkg;

    // serial link byte whose is_data is the dc level
    typedef struct packed
    {
        logic       is_data;
        logic [7:0] value;
    } link_byte_t;

    typedef struct packed
    {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [1:0] adr;
        logic [7:0] dat_w;
    } wb_req_t;

    localparam logic [1:0] ADR_COMM   = 2'd0;
    localparam logic [1:0] ADR_DATA   = 2'd1;
    localparam logic [1:0] ADR_STATUS = 2'd2;

endpackage

/* logic/tft_cmd_pkg.sv */
package tft_cmd_pkg;

    typedef enum logic [1:0]
    {
        KIND_COMM = 2'd0,
        KIND_DATA = 2'd1,
        KIND_WAIT = 2'd2
    } entry_kind_t;

    typedef struct packed
    {
        entry_kind_t kind;
        logic [7:0]  value; // byte, or wait time in ms
    } init_entry_t;

    localparam int INIT_LEN = 45;

    // power-up sequence ending with the memory write command
    localparam init_entry_t INIT_TABLE [0:INIT_LEN-1] = '{
        '{KIND_WAIT, 8'hff},
        '{KIND_COMM, 8'hc0}, '{KIND_DATA, 8'h17}, '{KIND_DATA, 8'h15},
        '{KIND_COMM, 8'hc1}, '{KIND_DATA, 8'h41},
        '{KIND_COMM, 8'hc5}, '{KIND_DATA, 8'h00}, '{KIND_DATA, 8'h12}, '{KIND_DATA, 8'h80},
        '{KIND_COMM, 8'h36}, '{KIND_DATA, 8'h48}, // memory access control
        '{KIND_COMM, 8'h3a}, '{KIND_DATA, 8'h66}, // 18 bit pixels
        '{KIND_COMM, 8'hb0}, '{KIND_DATA, 8'h80},
        '{KIND_COMM, 8'hb1}, '{KIND_DATA, 8'ha0},
        '{KIND_COMM, 8'hb6}, '{KIND_DATA, 8'h02}, '{KIND_DATA, 8'h02},
        '{KIND_COMM, 8'he9}, '{KIND_DATA, 8'h00},
        '{KIND_COMM, 8'hf7}, '{KIND_DATA, 8'ha9}, '{KIND_DATA, 8'h51},
        '{KIND_DATA, 8'h2c}, '{KIND_DATA, 8'h82},
        '{KIND_COMM, 8'h11}, // sleep out
        '{KIND_WAIT, 8'hff},
        '{KIND_COMM, 8'h29}, '{KIND_COMM, 8'h21}, '{KIND_COMM, 8'h34},
        '{KIND_WAIT, 8'hff},
        '{KIND_COMM, 8'h2a}, '{KIND_DATA, 8'h00}, '{KIND_DATA, 8'h10},
        '{KIND_DATA, 8'h00}, '{KIND_DATA, 8'h20}, // column window
        '{KIND_COMM, 8'h2b}, '{KIND_DATA, 8'h00}, '{KIND_DATA, 8'h10},
        '{KIND_DATA, 8'h00}, '{KIND_DATA, 8'h20}, // page window
        '{KIND_COMM, 8'h2c}
    };

endpackage

/* logic/tft_ctrl_top.sv */
`timescale 1ns/1ps

module tft_ctrl_top
#(
    parameter int CYCLES_PER_MS = 100000,
    parameter int SCLK_HALF     = 4
)
(
    input  logic                 clk,
    input  logic                 global_reset,
    input  tft_bus_pkg::wb_req_t wb,
    output logic                 ack,
    output logic [7:0]           dat_r,
    output logic                 sclk,
    output logic                 mosi,
    output logic                 cs_n,
    output logic                 dc
);

    tft_bus_pkg::link_byte_t host_byte;
    logic                    host_valid;
    logic                    host_ready;
    tft_bus_pkg::link_byte_t tx_byte;
    logic                    tx_valid;
    logic                    tx_ready;
    logic                    init_done;
    logic                    link_busy;

    tft_wb_port u_wb_port
    (
        .clk(clk),
        .global_reset(global_reset),
        .wb(wb),
        .ack(ack),
        .dat_r(dat_r),
        .init_done(init_done),
        .link_busy(link_busy),
        .host_byte(host_byte),
        .host_valid(host_valid),
        .host_ready(host_ready)
    );

    tft_init_seq
    #(
        .CYCLES_PER_MS(CYCLES_PER_MS)
    )
    u_init_seq
    (
        .clk(clk),
        .global_reset(global_reset),
        .host_byte(host_byte),
        .host_valid(host_valid),
        .host_ready(host_ready),
        .tx_byte(tx_byte),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .init_done(init_done)
    );

    tft_spi_tx
    #(
        .SCLK_HALF(SCLK_HALF)
    )
    u_spi_tx
    (
        .clk(clk),
        .global_reset(global_reset),
        .tx_byte(tx_byte),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .link_busy(link_busy),
        .sclk(sclk),
        .mosi(mosi),
        .cs_n(cs_n),
        .dc(dc)
    );

endmodule

/* logic/tft_init_seq.sv */
`timescale 1ns/1ps

module tft_init_seq
#(
    parameter int CYCLES_PER_MS = 100000
)
(
    input  logic                    clk,
    input  logic                    global_reset,
    input  tft_bus_pkg::link_byte_t host_byte,
    input  logic                    host_valid,
    output logic                    host_ready,
    output tft_bus_pkg::link_byte_t tx_byte,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    output logic                    init_done
);

    localparam int IDX_W = $clog2(tft_cmd_pkg::INIT_LEN);

    logic [IDX_W-1:0]         idx;
    tft_cmd_pkg::init_entry_t entry;
    logic                     is_wait;
    logic                     can_step;
    logic                     table_valid;
    logic                     step;
    logic                     timer_start;
    logic                     timer_free;
    tft_bus_pkg::link_byte_t  table_byte;

    assign entry   = tft_cmd_pkg::INIT_TABLE[idx];
    assign is_wait = (entry.kind == tft_cmd_pkg::KIND_WAIT);

    // waits also hold off until the link is idle
    assign can_step    = !init_done && timer_free && tx_ready;
    assign table_valid = can_step && !is_wait;
    assign timer_start = can_step && is_wait;
    assign step        = timer_start || table_valid; // entry consumed at this edge

    assign table_byte.is_data = (entry.kind == tft_cmd_pkg::KIND_DATA);
    assign table_byte.value   = entry.value;

    // after the table, host bytes go straight through
    assign tx_byte    = init_done ? host_byte : table_byte;
    assign tx_valid   = init_done ? (host_valid && tx_ready) : table_valid;
    assign host_ready = init_done && tx_ready;

    always_ff @(posedge clk)
    begin
        if (global_reset)
        begin
            idx       <= '0;
            init_done <= 1'b0;
        end
        else if (step)
        begin
            if (idx == IDX_W'(tft_cmd_pkg::INIT_LEN - 1))
                init_done <= 1'b1;
            else
                idx <= idx + 1'b1;
        end
    end

    tft_ms_delay
    #(
        .CYCLES_PER_MS(CYCLES_PER_MS)
    )
    u_ms_delay
    (
        .clk(clk),
        .global_reset(global_reset),
        .start(timer_start),
        .ms(entry.value),
        .free(timer_free)
    );

endmodule

/* logic/tft_ms_delay.sv */
`timescale 1ns/1ps

module tft_ms_delay
#(
    parameter int CYCLES_PER_MS = 100000
)
(
    input  logic       clk,
    input  logic       global_reset,
    input  logic       start,
    input  logic [7:0] ms,
    output logic       free
);

    localparam int PRE_W = (CYCLES_PER_MS > 1) ? $clog2(CYCLES_PER_MS) : 1;

    logic [PRE_W-1:0] pre;
    logic [7:0]       ms_left;
    logic             busy;

    assign free = !busy;

    always_ff @(posedge clk)
    begin
        if (global_reset)
        begin
            busy    <= 1'b0;
            pre     <= '0;
            ms_left <= '0;
        end
        else if (start)
        begin
            busy    <= 1'b1;
            ms_left <= ms;
            pre     <= (ms == 8'd0) ? '0 : PRE_W'(CYCLES_PER_MS - 1); // zero ms is one cycle
        end
        else if (busy)
        begin
            if (pre != '0)
                pre <= pre - 1'b1;
            else if (ms_left <= 8'd1)
                busy <= 1'b0;
            else
            begin
                ms_left <= ms_left - 8'd1;
                pre     <= PRE_W'(CYCLES_PER_MS - 1);
            end
        end
    end

endmodule

/* logic/tft_spi_tx.sv */
`timescale 1ns/1ps

module tft_spi_tx
#(
    parameter int SCLK_HALF = 4
)
(
    input  logic                    clk,
    input  logic                    global_reset,
    input  tft_bus_pkg::link_byte_t tx_byte,
    input  logic                    tx_valid,
    output logic                    tx_ready,
    output logic                    link_busy,
    output logic                    sclk,
    output logic                    mosi,
    output logic                    cs_n,
    output logic                    dc
);

    localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

    logic             busy;
    logic [7:0]       shreg;
    logic             dc_r;
    logic             sclk_r;
    logic [DIV_W-1:0] div;
    logic [3:0]       bit_cnt;
    logic             half_tick;

    assign half_tick = (div == DIV_W'(SCLK_HALF - 1));

    assign tx_ready  = !busy;
    assign link_busy = busy;
    assign cs_n      = !busy;
    assign sclk      = sclk_r;
    assign mosi      = shreg[7]; // msb first
    assign dc        = dc_r;

    always_ff @(posedge clk)
    begin
        if (global_reset)
        begin
            busy    <= 1'b0;
            sclk_r  <= 1'b0;
            div     <= '0;
            bit_cnt <= '0;
            shreg   <= '0;
            dc_r    <= 1'b0;
        end
        else if (!busy)
        begin
            if (tx_valid)
            begin
                busy    <= 1'b1;
                shreg   <= tx_byte.value;
                dc_r    <= tx_byte.is_data;
                sclk_r  <= 1'b0;
                div     <= '0;
                bit_cnt <= '0;
            end
        end
        else if (bit_cnt[3])
            busy <= 1'b0; // one cycle past the last falling edge
        else if (half_tick)
        begin
            div    <= '0;
            sclk_r <= !sclk_r;
            if (sclk_r)
            begin
                shreg   <= {shreg[6:0], 1'b0}; // next bit on falling edge
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
        else
            div <= div + 1'b1;
    end

endmodule

/* logic/tft_wb_port.sv */
`timescale 1ns/1ps

module tft_wb_port
(
    input  logic                    clk,
    input  logic                    global_reset,
    input  tft_bus_pkg::wb_req_t    wb,
    output logic                    ack,
    output logic [7:0]              dat_r,
    input  logic                    init_done,
    input  logic                    link_busy,
    output tft_bus_pkg::link_byte_t host_byte,
    output logic                    host_valid,
    input  logic                    host_ready
);

    logic req;
    logic byte_adr;
    logic take;
    logic captured; // byte taken last edge, ack follows
    logic hold_valid;

    assign req      = wb.cyc && wb.stb && !ack && !captured;
    assign byte_adr = (wb.adr == tft_bus_pkg::ADR_COMM) || (wb.adr == tft_bus_pkg::ADR_DATA);
    assign take     = req && wb.we && byte_adr && !hold_valid;

    assign host_valid = hold_valid;

    always_ff @(posedge clk)
    begin
        if (global_reset)
        begin
            ack        <= 1'b0;
            captured   <= 1'b0;
            hold_valid <= 1'b0;
        end
        else
        begin
            ack      <= 1'b0;
            captured <= 1'b0;
            if (hold_valid && host_ready)
                hold_valid <= 1'b0;
            if (captured)
                ack <= 1'b1;
            else if (take)
            begin
                hold_valid <= 1'b1;
                captured   <= 1'b1;
            end
            else if (req && !(wb.we && byte_adr))
                ack <= 1'b1; // reads and writes to other addresses
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            host_byte.is_data <= (wb.adr == tft_bus_pkg::ADR_DATA);
            host_byte.value   <= wb.dat_w;
        end
        if (req && !wb.we)
        begin
            if (wb.adr == tft_bus_pkg::ADR_STATUS)
                dat_r <= {6'b0, link_busy, init_done};
            else
                dat_r <= 8'h00;
        end
    end

endmodule

/* sim.f */
logic/tft_cmd_pkg.sv
logic/tft_bus_pkg.sv
logic/tft_wb_port.sv
logic/tft_ms_delay.sv
logic/tft_init_seq.sv
logic/tft_spi_tx.sv
logic/tft_ctrl_top.sv
verification/tft_clk_gen.sv
verification/tft_ctrl_tb.sv

/* verification/tft_clk_gen.sv */
`timescale 1ns/1ps

module tft_clk_gen
#(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 2
)
(
    output logic clk,
    output logic global_reset
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial
    begin
        global_reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        global_reset <= 1'b0; // released on a falling edge
    end

endmodule

/* verification/tft_ctrl_tb.sv */
`timescale 1ns/1ps

module tft_ctrl_tb;

    localparam int CYCLES_PER_MS = 4;
    localparam int SCLK_HALF     = 2;
    localparam int FRAME_CYCLES  = 16 * SCLK_HALF + 1; // cs_n low time of one byte
    localparam int BURST_LEN     = 20;
    localparam int HOST_BYTES    = BURST_LEN + 2;

    logic                    clk;
    logic                    global_reset;
    tft_bus_pkg::wb_req_t    wb;
    logic                    ack;
    logic [7:0]              dat_r;
    logic                    sclk;
    logic                    mosi;
    logic                    cs_n;
    logic                    dc;

    // expected link bytes and the idle gap each one needs before it
    tft_bus_pkg::link_byte_t exp_q[$];
    int                      gap_q[$];
    tft_bus_pkg::link_byte_t exp_now;
    tft_bus_pkg::link_byte_t got;
    int                      table_bytes = 0;

    int         cyc_cnt     = 0;
    int         last_rise   = 0;
    int         gap_seen    = 0;
    int         gap_need    = 0;
    int         low_cycles  = 0;
    int         shift_bits  = 0;
    int         link_starts = 0;
    int         bytes_seen  = 0;
    logic [7:0] shift_val   = '0;
    logic       cs_prev     = 1'b1;
    logic       sclk_prev   = 1'b0;
    logic       byte_done   = 1'b0;
    logic       gap_chk     = 1'b0;
    logic       extra       = 1'b0;

    logic       rd_active = 1'b0;
    logic       wr_active = 1'b0;
    logic [7:0] exp_rd    = '0;
    int         wr_done   = 0;
    logic       rd_req;

    assign rd_req = wb.cyc && wb.stb && !wb.we;

    tft_clk_gen u_clk_gen
    (
        .clk(clk),
        .global_reset(global_reset)
    );

    tft_ctrl_top
    #(
        .CYCLES_PER_MS(CYCLES_PER_MS),
        .SCLK_HALF(SCLK_HALF)
    )
    uut
    (
        .clk(clk),
        .global_reset(global_reset),
        .wb(wb),
        .ack(ack),
        .dat_r(dat_r),
        .sclk(sclk),
        .mosi(mosi),
        .cs_n(cs_n),
        .dc(dc)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic int budget_cycles();
        int wait_ms;
        wait_ms = 0;
        for (int i = 0; i < tft_cmd_pkg::INIT_LEN; i++)
        begin
            if (tft_cmd_pkg::INIT_TABLE[i].kind == tft_cmd_pkg::KIND_WAIT)
                wait_ms += int'(tft_cmd_pkg::INIT_TABLE[i].value);
        end
        return 4 * (wait_ms * CYCLES_PER_MS
                    + (tft_cmd_pkg::INIT_LEN + HOST_BYTES) * 16 * SCLK_HALF);
    endfunction

    // serial monitor sampling the link once per cycle
    always @(negedge clk)
    begin
        cyc_cnt   = cyc_cnt + 1;
        byte_done = 1'b0;
        gap_chk   = 1'b0;
        if (global_reset)
            last_rise = cyc_cnt;
        else
        begin
            if (!cs_n && cs_prev)
            begin
                gap_chk     = 1'b1;
                gap_seen    = cyc_cnt - last_rise;
                gap_need    = (gap_q.size() > 0) ? gap_q.pop_front() : 0;
                link_starts = link_starts + 1;
                low_cycles  = 0;
                shift_bits  = 0;
            end
            if (!cs_n)
            begin
                low_cycles = low_cycles + 1;
                if (sclk && !sclk_prev)
                begin
                    shift_val  = {shift_val[6:0], mosi}; // panel samples on rising sclk
                    shift_bits = shift_bits + 1;
                end
            end
            if (cs_n && !cs_prev)
            begin
                byte_done   = 1'b1;
                got.is_data = dc;
                got.value   = shift_val;
                last_rise   = cyc_cnt;
                bytes_seen  = bytes_seen + 1;
                extra       = (exp_q.size() == 0);
                if (!extra)
                    exp_now = exp_q.pop_front();
            end
        end
        cs_prev   = cs_n;
        sclk_prev = sclk;
    end

    link_byte_order: assert property (@(posedge clk) disable iff (global_reset)
        byte_done && !extra |-> got == exp_now)
    else
        stop_with_failure($sformatf("MISMATCH dc,mosi byte: expected %h got %h", exp_now, got));

    no_extra_byte: assert property (@(posedge clk) disable iff (global_reset)
        byte_done |-> !extra)
    else
        stop_with_failure("a byte appeared on the link that the host never sent");

    bit_count: assert property (@(posedge clk) disable iff (global_reset)
        byte_done |-> shift_bits == 8)
    else
        stop_with_failure($sformatf("MISMATCH sclk rising edges: expected %h got %h",
                                    8, shift_bits));

    frame_length: assert property (@(posedge clk) disable iff (global_reset)
        byte_done |-> low_cycles == FRAME_CYCLES)
    else
        stop_with_failure($sformatf("MISMATCH cs_n low cycles: expected %h got %h",
                                    FRAME_CYCLES, low_cycles));

    wait_gap: assert property (@(posedge clk) disable iff (global_reset)
        gap_chk |-> gap_seen >= gap_need)
    else
        stop_with_failure($sformatf("gap before link byte %0d was %0d cycles, needs %0d",
                                    link_starts, gap_seen, gap_need));

    read_ack_timing: assert property (@(posedge clk) disable iff (global_reset)
        $rose(rd_req) |=> ack)
    else
        stop_with_failure("a read was not acknowledged one cycle after stb");

    read_data: assert property (@(posedge clk) disable iff (global_reset)
        ack && rd_active |-> dat_r == exp_rd)
    else
        stop_with_failure($sformatf("MISMATCH dat_r: expected %h got %h", exp_rd, dat_r));

    // a write may only complete once the previous host byte went out
    write_backpressure: assert property (@(posedge clk) disable iff (global_reset)
        ack && wr_active |-> (wr_done <= 1) || (link_starts - table_bytes + 1 >= wr_done))
    else
        stop_with_failure("a write was acknowledged while the holding register was full");

    idle_sclk: assert property (@(posedge clk) disable iff (global_reset)
        cs_n |-> !sclk)
    else
        stop_with_failure("sclk was high while cs_n was high");

    dc_steady: assert property (@(posedge clk) disable iff (global_reset)
        !cs_n && $past(!cs_n) |-> $stable(dc))
    else
        stop_with_failure("dc changed while a byte was being shifted");

    reset_state: assert property (@(posedge clk)
        $fell(global_reset) |-> cs_n && !sclk && !ack)
    else
        stop_with_failure("link and bus outputs were not idle after reset");

    task automatic send_host_byte(input logic [1:0] adr, input logic [7:0] value);
        tft_bus_pkg::link_byte_t b;
        b.is_data = (adr == tft_bus_pkg::ADR_DATA);
        b.value   = value;
        exp_q.push_back(b);
        gap_q.push_back(0);
        @(negedge clk);
        wr_active = 1'b1;
        wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: value};
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        wb      = '0;
        wr_done = wr_done + 1;
        @(negedge clk);
        wr_active = 1'b0;
    endtask

    task automatic fetch_register(input logic [1:0] adr, input logic [7:0] expected);
        @(negedge clk);
        exp_rd    = expected;
        rd_active = 1'b1;
        wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: 8'h00};
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        wb = '0;
        @(negedge clk);
        rd_active = 1'b0;
    endtask

    task automatic write_command(input logic [7:0] value);
        send_host_byte(tft_bus_pkg::ADR_COMM, value);
    endtask

    task automatic write_data(input logic [7:0] value);
        send_host_byte(tft_bus_pkg::ADR_DATA, value);
    endtask

    task automatic read_status(input logic expect_done, input logic expect_busy);
        fetch_register(tft_bus_pkg::ADR_STATUS, {6'b0, expect_busy, expect_done});
    endtask

    task automatic read_unmapped();
        fetch_register(2'd3, 8'h00);
    endtask

    initial
    begin
        int limit;
        limit = budget_cycles();
        repeat (limit) @(posedge clk);
        stop_with_failure($sformatf("timeout, no result after %0d cycles", limit));
    end

    initial
    begin
        int         gap;
        logic [7:0] value;
        logic       pick;
        wb = '0;
        void'($urandom(67));
        for (int i = 0; i < tft_cmd_pkg::INIT_LEN; i++)
        begin
            gap = 0;
            if (i > 0)
            begin
                if (tft_cmd_pkg::INIT_TABLE[i-1].kind == tft_cmd_pkg::KIND_WAIT)
                    gap = int'(tft_cmd_pkg::INIT_TABLE[i-1].value) * CYCLES_PER_MS;
            end
            if (tft_cmd_pkg::INIT_TABLE[i].kind != tft_cmd_pkg::KIND_WAIT)
            begin
                exp_q.push_back('{tft_cmd_pkg::INIT_TABLE[i].kind == tft_cmd_pkg::KIND_DATA,
                                  tft_cmd_pkg::INIT_TABLE[i].value});
                gap_q.push_back(gap);
                table_bytes = table_bytes + 1;
            end
        end
        wait (global_reset === 1'b0);
        read_status(1'b0, 1'b0); // first wait entry still running
        read_unmapped();
        write_command(8'($urandom));
        write_data(8'($urandom)); // held off until the table is done
        while (bytes_seen < table_bytes)
            @(negedge clk);
        read_status(1'b1, 1'b1); // first host byte still shifting
        repeat (BURST_LEN)
        begin
            value = 8'($urandom);
            pick  = 1'($urandom);
            if (pick)
                write_data(value);
            else
                write_command(value);
        end
        while (exp_q.size() != 0)
            @(negedge clk);
        read_status(1'b1, 1'b0);
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        if (bytes_seen != table_bytes + HOST_BYTES)
            stop_with_failure($sformatf("MISMATCH link byte count: expected %h got %h",
                                        table_bytes + HOST_BYTES, bytes_seen));
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule
